// File: design/cap_pipe_macros.svh
/*
 * Widths, register count and instruction encodings
 * for the reduced capability pipeline
 */
`ifndef CAP_PIPE_MACROS_SVH
`define CAP_PIPE_MACROS_SVH

`define CP_XLEN   32
`define CP_INSN_W 32
`define CP_NREGS  32
`define CP_REG_W  5

// Major opcodes
`define CP_OPC_OPIMM 7'b0010011
`define CP_OPC_CAP   7'b1011011

// Capability group, funct3 == 000
`define CP_F7_CINCOFFSET 7'b0010001
`define CP_F7_CSUB       7'b0010100
`define CP_F7_UNARY      7'b1111111

// Unary group selects on the rs2 field
`define CP_R2_CMOVE     5'h0a
`define CP_R2_CCLEARTAG 5'h0b
`define CP_R2_CGETTAG   5'h04

`endif

// File: design/cap_types_pkg.sv
/*
 * Reduced capability type: tag bit plus address,
 * with the almighty reset value and the null value
 */
`default_nettype none

`include "cap_pipe_macros.svh"

package cap_types_pkg;

    typedef struct packed {
        logic                tag;
        logic [`CP_XLEN-1:0] addr;
    } cap_t;

    // Held by every register after reset
    localparam cap_t CAP_ALMIGHTY = '{
        tag:  1'b1,
        addr: '0
    };

    // Plain integer zero, no authority
    localparam cap_t CAP_NULL = '{
        tag:  1'b0,
        addr: '0
    };

endpackage

`default_nettype wire

// File: design/pipe_types_pkg.sv
/*
 * Operation enum and the structs passed between
 * decoder, operand stage and ALU stage
 */
`default_nettype none

`include "cap_pipe_macros.svh"

package pipe_types_pkg;

    import cap_types_pkg::*;

    typedef enum logic [2:0] {
        OP_ADDI,
        OP_CINCOFFSET,
        OP_CSUB,
        OP_CMOVE,
        OP_CCLEARTAG,
        OP_CGETTAG,
        OP_ILLEGAL
    } op_e;

    // Decoder to operand stage
    typedef struct packed {
        op_e                  op;
        logic [`CP_REG_W-1:0] rd;
        logic [`CP_REG_W-1:0] r1;
        logic [`CP_REG_W-1:0] r2;
        logic [`CP_XLEN-1:0]  imm;   // I-immediate, sign extended
    } dec_insn_t;

    // Operand stage to ALU stage
    typedef struct packed {
        op_e                  op;
        logic [`CP_REG_W-1:0] rd;
        logic [`CP_XLEN-1:0]  imm;
        cap_t                 c1;
        cap_t                 c2;
    } exec_req_t;

    // Result of one instruction
    typedef struct packed {
        logic [`CP_REG_W-1:0] rd;
        cap_t                 value;
        logic                 exc;   // Illegal encoding
    } retire_t;

endpackage

`default_nettype wire

// File: design/insn_decoder.sv
/*
 * Instruction decoder: field split, op select,
 * immediate sign extension, one register stage
 */
`timescale 1ns/100ps
`default_nettype none

`include "cap_pipe_macros.svh"

module insn_decoder (
    input  wire logic                    CLK,
    input  wire logic                    rst_n,
    input  wire logic                    insn_valid,
    input  wire logic [`CP_INSN_W-1:0]   insn,
    output logic                         dec_valid,
    output pipe_types_pkg::dec_insn_t    dec
);

    import pipe_types_pkg::*;

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`CP_REG_W-1:0] rd;
    logic [`CP_REG_W-1:0] rs1;
    logic [`CP_REG_W-1:0] rs2;
    op_e                  op;

    assign opcode = insn[6:0];
    assign rd     = insn[11:7];
    assign funct3 = insn[14:12];
    assign rs1    = insn[19:15];
    assign rs2    = insn[24:20];
    assign funct7 = insn[31:25];

    always_comb begin
        op = OP_ILLEGAL;
        if (opcode == `CP_OPC_OPIMM && funct3 == 3'b000) begin
            op = OP_ADDI;
        end else if (opcode == `CP_OPC_CAP && funct3 == 3'b000) begin
            case (funct7)
                `CP_F7_CINCOFFSET: op = OP_CINCOFFSET;
                `CP_F7_CSUB:       op = OP_CSUB;
                `CP_F7_UNARY: begin
                    case (rs2)   // rs2 is a sub-opcode here
                        `CP_R2_CMOVE:     op = OP_CMOVE;
                        `CP_R2_CCLEARTAG: op = OP_CCLEARTAG;
                        `CP_R2_CGETTAG:   op = OP_CGETTAG;
                        default:          op = OP_ILLEGAL;
                    endcase
                end
                default: op = OP_ILLEGAL;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= insn_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (insn_valid) begin
            dec.op  <= op;
            dec.rd  <= rd;
            dec.r1  <= rs1;
            dec.r2  <= rs2;
            dec.imm <= {{(`CP_XLEN-12){insn[31]}}, insn[31:20]};
        end
    end

    a_dec_latency: assert property (@(posedge CLK) disable iff (!rst_n)
        dec_valid == $past(insn_valid));

endmodule

`default_nettype wire

// File: design/operand_stage.sv
/*
 * Capability register file with retire write port,
 * operand read with forwarding, request register
 */
`timescale 1ns/100ps
`default_nettype none

`include "cap_pipe_macros.svh"

module operand_stage (
    input  wire logic                      CLK,
    input  wire logic                      rst_n,
    input  wire logic                      dec_valid,
    input  wire pipe_types_pkg::dec_insn_t dec,
    input  wire logic                      pend_valid,
    input  wire pipe_types_pkg::retire_t   pend,
    input  wire logic                      retire_valid,
    input  wire pipe_types_pkg::retire_t   retire,
    output logic                           req_valid,
    output pipe_types_pkg::exec_req_t      req
);

    import cap_types_pkg::*;
    import pipe_types_pkg::*;

    cap_t regs [`CP_NREGS];
    cap_t c1;
    cap_t c2;

    // Write port, results with no exception and a nonzero rd
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CP_NREGS; i++) begin
                regs[i] <= CAP_ALMIGHTY;
            end
        end else if (retire_valid && !retire.exc && retire.rd != '0) begin
            regs[retire.rd] <= retire.value;
        end
    end

    // x0 first, then the ALU result, the retiring result and the file
    function automatic cap_t read_src(input logic [`CP_REG_W-1:0] r);
        if (r == '0) begin
            return CAP_NULL;
        end else if (pend_valid && !pend.exc && pend.rd == r) begin
            return pend.value;
        end else if (retire_valid && !retire.exc && retire.rd == r) begin
            return retire.value;   // Lands in the file on this edge
        end
        return regs[r];
    endfunction

    always_comb begin
        c1 = read_src(dec.r1);
        c2 = read_src(dec.r2);
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= dec_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (dec_valid) begin
            req.op  <= dec.op;
            req.rd  <= dec.rd;
            req.imm <= dec.imm;
            req.c1  <= c1;
            req.c2  <= c2;
        end
    end

    a_r1_zero_null: assert property (@(posedge CLK) disable iff (!rst_n)
        dec_valid && dec.r1 == '0 |=> req_valid && req.c1 == CAP_NULL);

endmodule

`default_nettype wire

// File: design/cap_alu_stage.sv
/*
 * Capability execution stage: result per operation,
 * combinational pending result and registered retire
 */
`timescale 1ns/100ps
`default_nettype none

`include "cap_pipe_macros.svh"

module cap_alu_stage (
    input  wire logic                      CLK,
    input  wire logic                      rst_n,
    input  wire logic                      req_valid,
    input  wire pipe_types_pkg::exec_req_t req,
    output logic                           pend_valid,
    output pipe_types_pkg::retire_t        pend,
    output logic                           retire_valid,
    output pipe_types_pkg::retire_t        retire
);

    import cap_types_pkg::*;
    import pipe_types_pkg::*;

    retire_t res;

    always_comb begin
        res.rd    = req.rd;
        res.value = CAP_NULL;   // untagged zero unless set below
        res.exc   = 1'b0;
        case (req.op)
            OP_ADDI: begin
                res.value.addr = req.c1.addr + req.imm;
            end
            OP_CINCOFFSET: begin
                res.value.tag  = req.c1.tag;
                res.value.addr = req.c1.addr + req.c2.addr;
            end
            OP_CSUB: begin
                res.value.addr = req.c1.addr - req.c2.addr;
            end
            OP_CMOVE: begin
                res.value = req.c1;
            end
            OP_CCLEARTAG: begin
                res.value.addr = req.c1.addr;
            end
            OP_CGETTAG: begin
                res.value.addr = `CP_XLEN'(req.c1.tag);
            end
            default: begin
                res.exc = 1'b1;   // Illegal, value stays null
            end
        endcase
    end

    // Seen by the operand stage for forwarding
    assign pend_valid = req_valid;
    assign pend       = res;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= req_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid) begin
            retire <= res;
        end
    end

    a_retire_latency: assert property (@(posedge CLK) disable iff (!rst_n)
        retire_valid == $past(req_valid));

endmodule

`default_nettype wire

// File: design/cap_pipe_top.sv
/*
 * Capability pipeline top level:
 * decoder, operand stage and ALU stage
 */
`timescale 1ns/100ps
`default_nettype none

module cap_pipe_top (
    input  wire logic                CLK,
    input  wire logic                rst_n,
    input  wire logic                insn_valid,
    input  wire logic [31:0]         insn,
    output logic                     retire_valid,
    output pipe_types_pkg::retire_t  retire
);

    import pipe_types_pkg::*;

    logic      dec_valid;
    dec_insn_t dec;
    logic      req_valid;
    exec_req_t req;
    logic      pend_valid;
    retire_t   pend;

    insn_decoder decoder_i (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .insn_valid (insn_valid),
        .insn       (insn),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    operand_stage operand_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .dec_valid    (dec_valid),
        .dec          (dec),
        .pend_valid   (pend_valid),
        .pend         (pend),
        .retire_valid (retire_valid),   // Register file write port
        .retire       (retire),
        .req_valid    (req_valid),
        .req          (req)
    );

    cap_alu_stage alu_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .pend_valid   (pend_valid),
        .pend         (pend),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// File: test/tb_cap_pipe.sv
/*
 * Directed testbench for the capability pipeline:
 * program-order reference model, retire checker, tests
 */
`timescale 1ns/100ps
`default_nettype none

`include "cap_pipe_macros.svh"

module tb_cap_pipe;

    import cap_types_pkg::*;
    import pipe_types_pkg::*;

    typedef struct packed {
        int      edge_no;   // Cycle in which the instruction is driven
        retire_t res;
    } expect_t;

    logic        CLK = 1'b0;
    logic        rst_n = 1'b0;
    logic        insn_valid = 1'b0;
    logic [31:0] insn = '0;
    logic        retire_valid;
    retire_t     retire;

    cap_t    model_regs [`CP_NREGS];
    expect_t exp_q [$];
    int      edge_cnt = 0;
    int      checks = 0;
    int      errors = 0;

    cap_pipe_top dut_i (.*);

    always #10 CLK = ~CLK;

    always @(posedge CLK) edge_cnt <= edge_cnt + 1;

    task automatic check(input string name, input logic [63:0] got,
                         input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    // Retire monitor on the falling edge
    always @(negedge CLK) begin
        expect_t e;
        if (rst_n && retire_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected retirement at %0d ns with nothing outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                check("retire latency", 64'(edge_cnt - e.edge_no), 64'd3);
                check("retire.rd", 64'(retire.rd), 64'(e.res.rd));
                check("retire.value", 64'(retire.value), 64'(e.res.value));
                check("retire.exc", 64'(retire.exc), 64'(e.res.exc));
            end
        end
    end

    // x0 always reads as null
    function automatic cap_t read_model(input logic [4:0] r);
        if (r == '0) begin
            return CAP_NULL;
        end
        return model_regs[r];
    endfunction

    function automatic cap_t exec_model(input op_e op, input cap_t c1, input cap_t c2,
                                        input logic [11:0] imm);
        cap_t v;
        v = CAP_NULL;
        case (op)
            OP_ADDI:       v.addr = c1.addr + {{20{imm[11]}}, imm};
            OP_CINCOFFSET: v = '{tag: c1.tag, addr: c1.addr + c2.addr};
            OP_CSUB:       v.addr = c1.addr - c2.addr;
            OP_CMOVE:      v = c1;
            OP_CCLEARTAG:  v.addr = c1.addr;
            OP_CGETTAG:    v.addr = {31'b0, c1.tag};
            default:       v = CAP_NULL;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] encode(input op_e op, input logic [4:0] rd, rs1, rs2,
                                           input logic [11:0] imm);
        logic [31:0] w;
        case (op)
            OP_ADDI:       w = {imm, rs1, 3'b000, rd, `CP_OPC_OPIMM};
            OP_CINCOFFSET: w = {`CP_F7_CINCOFFSET, rs2, rs1, 3'b000, rd, `CP_OPC_CAP};
            OP_CSUB:       w = {`CP_F7_CSUB, rs2, rs1, 3'b000, rd, `CP_OPC_CAP};
            OP_CMOVE:      w = {`CP_F7_UNARY, `CP_R2_CMOVE, rs1, 3'b000, rd, `CP_OPC_CAP};
            OP_CCLEARTAG:  w = {`CP_F7_UNARY, `CP_R2_CCLEARTAG, rs1, 3'b000, rd, `CP_OPC_CAP};
            OP_CGETTAG:    w = {`CP_F7_UNARY, `CP_R2_CGETTAG, rs1, 3'b000, rd, `CP_OPC_CAP};
            default: begin
                case (imm[1:0])   // Four kinds of unmatched encoding
                    2'd0:    w = {imm, rs1, 3'b010, rd, `CP_OPC_OPIMM};
                    2'd1:    w = {7'h00, rs2, rs1, 3'b000, rd, `CP_OPC_CAP};
                    2'd2:    w = {`CP_F7_UNARY, 5'h1f, rs1, 3'b000, rd, `CP_OPC_CAP};
                    default: w = {`CP_F7_CSUB, rs2, rs1, 3'b001, rd, `CP_OPC_CAP};
                endcase
            end
        endcase
        return w;
    endfunction

    // Drives one instruction for the next rising edge and predicts its result
    task automatic send(input op_e op, input logic [4:0] rd, rs1, rs2,
                        input logic [11:0] imm);
        expect_t e;
        @(negedge CLK);
        e.edge_no   = edge_cnt;
        e.res.rd    = rd;
        e.res.exc   = (op == OP_ILLEGAL);
        e.res.value = exec_model(op, read_model(rs1), read_model(rs2), imm);
        if (!e.res.exc && rd != '0) begin
            model_regs[rd] = e.res.value;
        end
        exp_q.push_back(e);
        insn_valid = 1'b1;
        insn       = encode(op, rd, rs1, rs2, imm);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge CLK);
            insn_valid = 1'b0;
            insn       = $urandom();   // Junk while not valid
        end
    endtask

    // Waits until every outstanding instruction has retired
    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() > 0 && waited < 20) begin
            @(negedge CLK);
            waited++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("Timeout at %0d ns: %0d instructions never retired", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic test_reset_tags();
        for (int r = 0; r < `CP_NREGS; r++) begin
            send(OP_CGETTAG, 5'd0, 5'(r), 5'd0, 12'd0);
        end
        drain();
    endtask

    // Destinations kept to 16..31 so low registers stay tagged
    task automatic test_addi_csub();
        for (int i = 0; i < 24; i++) begin
            send(OP_ADDI, 5'($urandom_range(16, 31)), 5'($urandom_range(0, 31)), 5'd0,
                 12'($urandom()));
            send(OP_CSUB, 5'($urandom_range(16, 31)), 5'($urandom_range(0, 31)),
                 5'($urandom_range(0, 31)), 12'd0);
            idle($urandom_range(0, 2));
        end
        drain();
    endtask

    task automatic test_tag_ops();
        send(OP_CMOVE,      5'd6,  5'd1, 5'd0,  12'd0);
        send(OP_CINCOFFSET, 5'd7,  5'd6, 5'd20, 12'd0);
        send(OP_CCLEARTAG,  5'd8,  5'd7, 5'd0,  12'd0);
        send(OP_CMOVE,      5'd9,  5'd8, 5'd0,  12'd0);
        send(OP_ADDI,       5'd0,  5'd7, 5'd0,  12'h123);   // Dropped write
        send(OP_CMOVE,      5'd10, 5'd0, 5'd0,  12'd0);
        send(OP_CINCOFFSET, 5'd0,  5'd2, 5'd7,  12'd0);
        idle(4);
        send(OP_CGETTAG,    5'd11, 5'd0, 5'd0,  12'd0);
        send(OP_CINCOFFSET, 5'd12, 5'd3, 5'd0,  12'd0);
        drain();
    endtask

    task automatic test_forwarding();
        send(OP_ADDI,       5'd20, 5'd0,  5'd0,  12'h005);
        send(OP_ADDI,       5'd20, 5'd20, 5'd0,  12'h7f0);   // Distance one
        send(OP_CINCOFFSET, 5'd21, 5'd20, 5'd20, 12'd0);     // Both sources one rd
        send(OP_CSUB,       5'd22, 5'd20, 5'd21, 12'd0);     // Distance two and one
        send(OP_CMOVE,      5'd23, 5'd22, 5'd0,  12'd0);
        drain();
    endtask

    task automatic test_illegal();
        for (int k = 0; k < 4; k++) begin
            send(OP_ADDI,    5'd12, 5'd0,  5'd0, 12'(k + 'h50));
            idle(3);
            send(OP_ILLEGAL, 5'd12, 5'd3,  5'd4, 12'(k));
            send(OP_CMOVE,   5'd13, 5'd12, 5'd0, 12'd0);
            send(OP_CMOVE,   5'd14, 5'd12, 5'd0, 12'd0);
        end
        drain();
    endtask

    task automatic test_random_mix();
        for (int i = 0; i < 200; i++) begin
            send(op_e'($urandom_range(0, 6)), 5'($urandom()), 5'($urandom()),
                 5'($urandom()), 12'($urandom()));
            idle($urandom_range(0, 2));
        end
        drain();
    endtask

    initial begin
        void'($urandom(90295));
        for (int r = 0; r < `CP_NREGS; r++) begin
            model_regs[r] = CAP_ALMIGHTY;
        end
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        test_reset_tags();
        test_addi_csub();
        test_tag_ops();
        test_forwarding();
        test_illegal();
        test_random_mix();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/cap_types_pkg.sv
design/pipe_types_pkg.sv
design/insn_decoder.sv
design/operand_stage.sv
design/cap_alu_stage.sv
design/cap_pipe_top.sv
test/tb_cap_pipe.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the capability pipeline testbench with Verilator and runs it

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cap_pipe -f project.f &&
out="$(./obj_dir/Vtb_cap_pipe 2>&1 || echo "Simulator exited with an error")" &&
echo "$out" &&
grep -qx 'Result: PASSED' <<< "$out" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
